// File: Makefile
VERILATOR ?= verilator
TOP       ?= eth_rgmii_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/eth_consts.svh
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

// Frame delimiters.
`define ETH_PREAMBLE      8'h55
`define ETH_SFD           8'hD5
`define ETH_PREAMBLE_LEN  16'd7

// Byte sent in place of an aborted payload byte.
`define ETH_ERR_BYTE      8'hFE

// CRC register after a good frame, FCS included, before inversion.
`define ETH_CRC_RESIDUE   32'hDEBB20E3

// Inter-packet gap in clock cycles.
`define ETH_IPG_DEFAULT   16'd12
`define ETH_IPG_MIN       16'd1

// Register map.
`define REG_CTRL          3'd0
`define REG_IPG           3'd1
`define REG_TX_CNT        3'd2
`define REG_RX_OK_CNT     3'd3
`define REG_RX_BAD_CNT    3'd4

`define ETH_CTRL_DEFAULT  16'h0003

`endif

// File: project.f
+incdir+include
source/eth_pkg.sv
source/rgmii_adapter.sv
source/gmii_tx_framer.sv
source/gmii_rx_parser.sv
source/eth_ctrl_regs.sv
source/eth_rgmii_top.sv
verif/eth_rgmii_chk.sv
verif/eth_rgmii_tb.sv

// File: source/eth_ctrl_regs.sv
`timescale 1ns/1ps
`include "eth_consts.svh"

module eth_ctrl_regs (
  input  logic               gmii_clk_125m,
  input  logic               arst_n,
  input  logic               reg_wr,
  input  logic               reg_rd,
  input  eth_pkg::reg_addr_t reg_addr,
  input  eth_pkg::reg_data_t reg_wdata,
  input  logic               tx_frame_done,
  input  logic               rx_ok_evt,
  input  logic               rx_bad_evt,
  output eth_pkg::reg_data_t reg_rdata,
  output logic               tx_en,
  output logic               rx_en,
  output eth_pkg::reg_data_t ipg_len
);

  eth_pkg::reg_data_t ctrl;
  eth_pkg::reg_data_t ipg;
  eth_pkg::count_t    cnt [3];
  logic [2:0]         inc;
  logic [2:0]         ok_sync;
  logic [2:0]         bad_sync;

  assign tx_en   = ctrl[0];
  assign rx_en   = ctrl[1];
  assign ipg_len = ipg;

  // Order follows the counter addresses, TX first.
  assign inc = {bad_sync[2] ^ bad_sync[1], ok_sync[2] ^ ok_sync[1], tx_frame_done};

  // Receive events arrive as toggles from the receive clock.
  always_ff @(posedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      ok_sync  <= '0;
      bad_sync <= '0;
    end else begin
      ok_sync  <= {ok_sync[1:0], rx_ok_evt};
      bad_sync <= {bad_sync[1:0], rx_bad_evt};
    end
  end

  always_ff @(posedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= `ETH_CTRL_DEFAULT;
      ipg  <= `ETH_IPG_DEFAULT;
    end else if (reg_wr) begin
      if (reg_addr == `REG_CTRL) begin
        ctrl <= {14'h0000, reg_wdata[1:0]};
      end
      if (reg_addr == `REG_IPG) begin
        ipg <= (reg_wdata < `ETH_IPG_MIN) ? `ETH_IPG_MIN : reg_wdata;
      end
    end
  end

  // A write to a counter clears it, and the clear wins over a pending event.
  always_ff @(posedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (reg_wr && (reg_addr == `REG_TX_CNT + 3'(i))) begin
          cnt[i] <= '0;
        end else if (inc[i]) begin
          cnt[i] <= cnt[i] + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (reg_addr)
        `REG_CTRL:       reg_rdata <= ctrl;
        `REG_IPG:        reg_rdata <= ipg;
        `REG_TX_CNT:     reg_rdata <= cnt[0];
        `REG_RX_OK_CNT:  reg_rdata <= cnt[1];
        `REG_RX_BAD_CNT: reg_rdata <= cnt[2];
        default:         reg_rdata <= '0;
      endcase
    end
  end

endmodule : eth_ctrl_regs

// File: source/eth_pkg.sv
package eth_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [31:0] crc_t;
  typedef logic [2:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;
  typedef logic [15:0] count_t;

  typedef enum logic [2:0] {
    txs_idle,
    txs_preamble,
    txs_sfd,
    txs_data,
    txs_fcs,
    txs_abort,
    txs_gap
  } tx_state_t;

  typedef enum logic [1:0] {
    rxs_idle,
    rxs_hunt,
    rxs_data,
    rxs_drop
  } rx_state_t;

  // Reflected IEEE 802.3 polynomial.
  localparam crc_t CRC32_POLY = 32'hEDB88320;

  // One byte through the reflected CRC-32, LSB first.
  function automatic crc_t crc32_next(crc_t crc, byte_t dat);
    crc_t c;
    c = crc ^ {24'h000000, dat};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
    end
    return c;
  endfunction

endpackage

// File: source/eth_rgmii_top.sv
`timescale 1ns/1ps

module eth_rgmii_top (
  input  logic               gmii_clk_125m,
  input  logic               arst_n,
  input  logic               rgmii_rx_clk,
  input  eth_pkg::nibble_t   rgmii_rx_dat,
  input  logic               rgmii_rx_ctl,
  output logic               rgmii_gtx_clk,
  output eth_pkg::nibble_t   rgmii_tx_dat,
  output logic               rgmii_tx_ctl,
  input  eth_pkg::byte_t     tx_dat,
  input  logic               tx_val,
  input  logic               tx_last,
  input  logic               tx_abort,
  output logic               tx_ack,
  output logic               gmii_rx_clk,
  output eth_pkg::byte_t     rx_dat,
  output logic               rx_val,
  output logic               rx_end,
  output logic               rx_ok,
  input  logic               reg_wr,
  input  logic               reg_rd,
  input  eth_pkg::reg_addr_t reg_addr,
  input  eth_pkg::reg_data_t reg_wdata,
  output eth_pkg::reg_data_t reg_rdata
);

  eth_pkg::byte_t     gmii_tx_dat;
  logic               gmii_tx_val;
  logic               gmii_tx_err;
  eth_pkg::byte_t     gmii_rx_dat;
  logic               gmii_rx_val;
  logic               gmii_rx_err;
  logic               tx_en;
  logic               rx_en;
  eth_pkg::reg_data_t ipg_len;
  logic               tx_frame_done;
  logic               rx_ok_evt;
  logic               rx_bad_evt;

  rgmii_adapter i_adapter (
    .arst_n        (arst_n),
    .rgmii_rx_clk  (rgmii_rx_clk),
    .rgmii_rx_dat  (rgmii_rx_dat),
    .rgmii_rx_ctl  (rgmii_rx_ctl),
    .rgmii_gtx_clk (rgmii_gtx_clk),
    .rgmii_tx_dat  (rgmii_tx_dat),
    .rgmii_tx_ctl  (rgmii_tx_ctl),
    .gmii_rx_clk   (gmii_rx_clk),
    .gmii_rx_dat   (gmii_rx_dat),
    .gmii_rx_val   (gmii_rx_val),
    .gmii_rx_err   (gmii_rx_err),
    .gmii_clk_125m (gmii_clk_125m),
    .gmii_tx_dat   (gmii_tx_dat),
    .gmii_tx_val   (gmii_tx_val),
    .gmii_tx_err   (gmii_tx_err)
  );

  gmii_tx_framer i_framer (
    .gmii_clk_125m (gmii_clk_125m),
    .arst_n        (arst_n),
    .tx_dat        (tx_dat),
    .tx_val        (tx_val),
    .tx_last       (tx_last),
    .tx_abort      (tx_abort),
    .tx_en         (tx_en),
    .ipg_len       (ipg_len),
    .tx_ack        (tx_ack),
    .gmii_tx_dat   (gmii_tx_dat),
    .gmii_tx_val   (gmii_tx_val),
    .gmii_tx_err   (gmii_tx_err),
    .tx_frame_done (tx_frame_done)
  );

  gmii_rx_parser i_parser (
    .gmii_rx_clk (gmii_rx_clk),
    .arst_n      (arst_n),
    .gmii_rx_dat (gmii_rx_dat),
    .gmii_rx_val (gmii_rx_val),
    .gmii_rx_err (gmii_rx_err),
    .rx_en       (rx_en),
    .rx_dat      (rx_dat),
    .rx_val      (rx_val),
    .rx_end      (rx_end),
    .rx_ok       (rx_ok),
    .rx_ok_evt   (rx_ok_evt),
    .rx_bad_evt  (rx_bad_evt)
  );

  eth_ctrl_regs i_regs (
    .gmii_clk_125m (gmii_clk_125m),
    .arst_n        (arst_n),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .tx_frame_done (tx_frame_done),
    .rx_ok_evt     (rx_ok_evt),
    .rx_bad_evt    (rx_bad_evt),
    .reg_rdata     (reg_rdata),
    .tx_en         (tx_en),
    .rx_en         (rx_en),
    .ipg_len       (ipg_len)
  );

endmodule : eth_rgmii_top

// File: source/gmii_rx_parser.sv
`timescale 1ns/1ps
`include "eth_consts.svh"

module gmii_rx_parser (
  input  logic           gmii_rx_clk,
  input  logic           arst_n,
  input  eth_pkg::byte_t gmii_rx_dat,
  input  logic           gmii_rx_val,
  input  logic           gmii_rx_err,
  input  logic           rx_en,
  output eth_pkg::byte_t rx_dat,
  output logic           rx_val,
  output logic           rx_end,
  output logic           rx_ok,
  output logic           rx_ok_evt,
  output logic           rx_bad_evt
);

  eth_pkg::rx_state_t       state;
  logic                     rx_en_meta;
  logic                     rx_en_sync;
  eth_pkg::byte_t [3:0]     dly;
  logic [2:0]               byte_cnt;
  logic                     err_seen;
  eth_pkg::crc_t            crc;
  logic                     frame_ok;

  // Byte count saturates at 5, the shortest frame worth judging.
  assign frame_ok = (crc == `ETH_CRC_RESIDUE) && !err_seen && (byte_cnt == 3'd5);

  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_en_meta <= 1'b0;
      rx_en_sync <= 1'b0;
    end else begin
      rx_en_meta <= rx_en;
      rx_en_sync <= rx_en_meta;
    end
  end

  // Four bytes in flight hold back the FCS.
  always_ff @(posedge gmii_rx_clk) begin
    if ((state == eth_pkg::rxs_data) && gmii_rx_val) begin
      dly    <= {dly[2:0], gmii_rx_dat};
      rx_dat <= dly[3];
    end
  end

  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= eth_pkg::rxs_idle;
      byte_cnt   <= '0;
      err_seen   <= 1'b0;
      crc        <= '1;
      rx_val     <= 1'b0;
      rx_end     <= 1'b0;
      rx_ok      <= 1'b0;
      rx_ok_evt  <= 1'b0;
      rx_bad_evt <= 1'b0;
    end else begin
      rx_val <= 1'b0;
      rx_end <= 1'b0;
      case (state)
        eth_pkg::rxs_idle: begin
          if (gmii_rx_val) begin
            byte_cnt <= '0;
            err_seen <= 1'b0;
            crc      <= '1;
            if (!rx_en_sync) begin
              state <= eth_pkg::rxs_drop;
            end else if (gmii_rx_dat == `ETH_SFD) begin
              state <= eth_pkg::rxs_data;
            end else begin
              state <= eth_pkg::rxs_hunt;
            end
          end
        end
        eth_pkg::rxs_hunt: begin
          if (!gmii_rx_val) begin
            state <= eth_pkg::rxs_idle;
          end else if (gmii_rx_dat == `ETH_SFD) begin
            state <= eth_pkg::rxs_data;
          end
        end
        eth_pkg::rxs_data: begin
          if (gmii_rx_val) begin
            crc      <= eth_pkg::crc32_next(crc, gmii_rx_dat);
            err_seen <= err_seen | gmii_rx_err;
            rx_val   <= (byte_cnt >= 3'd4);
            if (byte_cnt != 3'd5) begin
              byte_cnt <= byte_cnt + 3'd1;
            end
          end else begin
            state  <= eth_pkg::rxs_idle;
            rx_end <= 1'b1;
            rx_ok  <= frame_ok;
            if (frame_ok) begin
              rx_ok_evt <= ~rx_ok_evt;
            end else begin
              rx_bad_evt <= ~rx_bad_evt;
            end
          end
        end
        eth_pkg::rxs_drop: begin
          if (!gmii_rx_val) begin
            state <= eth_pkg::rxs_idle;
          end
        end
        default: state <= eth_pkg::rxs_idle;
      endcase
    end
  end

endmodule : gmii_rx_parser

// File: source/gmii_tx_framer.sv
`timescale 1ns/1ps
`include "eth_consts.svh"

module gmii_tx_framer (
  input  logic               gmii_clk_125m,
  input  logic               arst_n,
  input  eth_pkg::byte_t     tx_dat,
  input  logic               tx_val,
  input  logic               tx_last,
  input  logic               tx_abort,
  input  logic               tx_en,
  input  eth_pkg::reg_data_t ipg_len,
  output logic               tx_ack,
  output eth_pkg::byte_t     gmii_tx_dat,
  output logic               gmii_tx_val,
  output logic               gmii_tx_err,
  output logic               tx_frame_done
);

  eth_pkg::tx_state_t state;
  eth_pkg::reg_data_t cnt;
  eth_pkg::byte_t     dat_q;
  logic               last_q;
  eth_pkg::crc_t      crc;
  eth_pkg::crc_t      fcs;
  eth_pkg::tx_state_t after_frame;

  assign fcs = ~crc;

  // The idle cycle itself counts as one gap cycle.
  assign after_frame = (ipg_len > 16'd1) ? eth_pkg::txs_gap : eth_pkg::txs_idle;

  assign tx_ack = (state == eth_pkg::txs_sfd) ||
                  ((state == eth_pkg::txs_data) && !last_q);

  assign tx_frame_done = (state == eth_pkg::txs_fcs) && (cnt == 16'd3);

  always_comb begin
    gmii_tx_dat = 8'h00;
    gmii_tx_val = 1'b0;
    gmii_tx_err = 1'b0;
    case (state)
      eth_pkg::txs_preamble: begin
        gmii_tx_dat = `ETH_PREAMBLE;
        gmii_tx_val = 1'b1;
      end
      eth_pkg::txs_sfd: begin
        gmii_tx_dat = `ETH_SFD;
        gmii_tx_val = 1'b1;
      end
      eth_pkg::txs_data: begin
        gmii_tx_dat = dat_q;
        gmii_tx_val = 1'b1;
      end
      eth_pkg::txs_fcs: begin
        gmii_tx_dat = fcs[{cnt[1:0], 3'b000} +: 8];
        gmii_tx_val = 1'b1;
      end
      eth_pkg::txs_abort: begin
        gmii_tx_dat = `ETH_ERR_BYTE;
        gmii_tx_val = 1'b1;
        gmii_tx_err = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      state  <= eth_pkg::txs_idle;
      cnt    <= '0;
      last_q <= 1'b0;
      crc    <= '1;
    end else begin
      case (state)
        eth_pkg::txs_idle: begin
          if (tx_val && tx_en) begin
            state <= eth_pkg::txs_preamble;
            cnt   <= '0;
            crc   <= '1;
          end
        end
        eth_pkg::txs_preamble: begin
          if (cnt == `ETH_PREAMBLE_LEN - 16'd1) begin
            state <= eth_pkg::txs_sfd;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        eth_pkg::txs_sfd, eth_pkg::txs_data: begin
          if (!tx_ack) begin
            state <= eth_pkg::txs_fcs;
            cnt   <= '0;
          end else if (tx_abort) begin
            state <= eth_pkg::txs_abort;
          end else begin
            state  <= eth_pkg::txs_data;
            last_q <= tx_last;
            crc    <= eth_pkg::crc32_next(crc, tx_dat);
          end
        end
        eth_pkg::txs_fcs: begin
          if (cnt == 16'd3) begin
            state <= after_frame;
            cnt   <= 16'd1;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        eth_pkg::txs_abort: begin
          state <= after_frame;
          cnt   <= 16'd1;
        end
        eth_pkg::txs_gap: begin
          if (cnt >= ipg_len - 16'd1) begin
            state <= eth_pkg::txs_idle;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        default: state <= eth_pkg::txs_idle;
      endcase
    end
  end

  always_ff @(posedge gmii_clk_125m) begin
    if (tx_ack) begin
      dat_q <= tx_dat;
    end
  end

endmodule : gmii_tx_framer

// File: source/rgmii_adapter.sv
`timescale 1ns/1ps

module rgmii_adapter (
  input  logic             arst_n,
  input  logic             rgmii_rx_clk,
  input  eth_pkg::nibble_t rgmii_rx_dat,
  input  logic             rgmii_rx_ctl,
  output logic             rgmii_gtx_clk,
  output eth_pkg::nibble_t rgmii_tx_dat,
  output logic             rgmii_tx_ctl,
  output logic             gmii_rx_clk,
  output eth_pkg::byte_t   gmii_rx_dat,
  output logic             gmii_rx_val,
  output logic             gmii_rx_err,
  input  logic             gmii_clk_125m,
  input  eth_pkg::byte_t   gmii_tx_dat,
  input  logic             gmii_tx_val,
  input  logic             gmii_tx_err
);

  // Half-period words are {nibble, ctl}.
  logic [4:0] tx_hi_q;
  logic [4:0] tx_pos_q;
  logic [4:0] tx_neg_q;
  logic [4:0] tx_pins;
  logic [4:0] rx_hi_phase_q;

  assign rgmii_gtx_clk = gmii_clk_125m;
  assign gmii_rx_clk   = rgmii_rx_clk;

  always_ff @(posedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      tx_hi_q  <= '0;
      tx_pos_q <= '0;
    end else begin
      tx_hi_q  <= {gmii_tx_dat[7:4], gmii_tx_val ^ gmii_tx_err};
      tx_pos_q <= {gmii_tx_dat[3:0], gmii_tx_val} ^ tx_neg_q;
    end
  end

  always_ff @(negedge gmii_clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      tx_neg_q <= '0;
    end else begin
      tx_neg_q <= tx_hi_q ^ tx_pos_q;
    end
  end

  // Dual-edge output, the XOR shows whichever edge register was loaded last.
  assign tx_pins      = tx_pos_q ^ tx_neg_q;
  assign rgmii_tx_dat = tx_pins[4:1];
  assign rgmii_tx_ctl = tx_pins[0];

  // Clock is edge-aligned with data, so each half is read at the edge closing it.
  always_ff @(negedge rgmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_hi_phase_q <= '0;
    end else begin
      rx_hi_phase_q <= {rgmii_rx_dat, rgmii_rx_ctl};
    end
  end

  always_ff @(posedge rgmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      gmii_rx_val <= 1'b0;
      gmii_rx_err <= 1'b0;
    end else begin
      gmii_rx_val <= rx_hi_phase_q[0];
      gmii_rx_err <= rx_hi_phase_q[0] ^ rgmii_rx_ctl;
    end
  end

  always_ff @(posedge rgmii_rx_clk) begin
    gmii_rx_dat <= {rgmii_rx_dat, rx_hi_phase_q[4:1]};
  end

endmodule : rgmii_adapter

// File: verif/eth_rgmii_chk.sv
`timescale 1ns/1ps

module eth_rgmii_chk (
  input logic gmii_clk_125m,
  input logic gmii_rx_clk,
  input logic arst_n,
  input logic reg_wr,
  input logic reg_rd,
  input logic rx_val,
  input logic rx_end,
  input logic tx_ack,
  input logic tx_last,
  input logic tx_abort,
  input logic rgmii_tx_ctl
);

  int failures = 0;

  a_reg_access: assert property (@(posedge gmii_clk_125m) disable iff (!arst_n)
    !(reg_wr && reg_rd))
    else begin
      failures++;
      $error("reg_wr and reg_rd high together");
    end

  a_rx_end_alone: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
    !(rx_end && rx_val))
    else begin
      failures++;
      $error("rx_end together with rx_val");
    end

  // Final or aborted byte ends the payload handshake.
  a_ack_stops: assert property (@(posedge gmii_clk_125m) disable iff (!arst_n)
    (tx_ack && (tx_last || tx_abort)) |=> !tx_ack)
    else begin
      failures++;
      $error("tx_ack after the final byte");
    end

  a_ctl_reset: assert property (@(posedge gmii_clk_125m)
    !arst_n |-> !rgmii_tx_ctl)
    else begin
      failures++;
      $error("rgmii_tx_ctl high during reset");
    end

endmodule : eth_rgmii_chk

bind eth_rgmii_top eth_rgmii_chk i_chk (
  .gmii_clk_125m (gmii_clk_125m),
  .gmii_rx_clk   (gmii_rx_clk),
  .arst_n        (arst_n),
  .reg_wr        (reg_wr),
  .reg_rd        (reg_rd),
  .rx_val        (rx_val),
  .rx_end        (rx_end),
  .tx_ack        (tx_ack),
  .tx_last       (tx_last),
  .tx_abort      (tx_abort),
  .rgmii_tx_ctl  (rgmii_tx_ctl)
);

// File: verif/eth_rgmii_tb.sv
`timescale 1ns/1ps
`include "eth_consts.svh"

module eth_rgmii_tb;

  // Longest frame is preamble, SFD, 40 bytes, FCS and a 30-cycle gap.
  localparam int FRAME_COUNT      = 15;
  localparam int MAX_FRAME_CYCLES = 8 + 40 + 4 + 30;
  localparam int WATCHDOG_CYCLES  = FRAME_COUNT * MAX_FRAME_CYCLES + 1500;

  logic               gmii_clk_125m;
  logic               arst_n;
  logic               rgmii_rx_clk;
  eth_pkg::nibble_t   rgmii_rx_dat;
  logic               rgmii_rx_ctl;
  logic               rgmii_gtx_clk;
  eth_pkg::nibble_t   rgmii_tx_dat;
  logic               rgmii_tx_ctl;
  eth_pkg::byte_t     tx_dat;
  logic               tx_val;
  logic               tx_last;
  logic               tx_abort;
  logic               tx_ack;
  logic               gmii_rx_clk;
  eth_pkg::byte_t     rx_dat;
  logic               rx_val;
  logic               rx_end;
  logic               rx_ok;
  logic               reg_wr;
  logic               reg_rd;
  eth_pkg::reg_addr_t reg_addr;
  eth_pkg::reg_data_t reg_wdata;
  eth_pkg::reg_data_t reg_rdata;

  logic [31:0]        rng;
  int                 errors;
  int                 checks;
  int                 tests;
  int                 tx_cnt_m;
  int                 rx_ok_m;
  int                 rx_bad_m;
  int                 rx_bytes;
  eth_pkg::byte_t     exp_bytes [$];
  int                 exp_len [$];
  logic               exp_ok [$];

  // Loopback on the pins.
  assign rgmii_rx_clk = rgmii_gtx_clk;
  assign rgmii_rx_dat = rgmii_tx_dat;
  assign rgmii_rx_ctl = rgmii_tx_ctl;

  eth_rgmii_top i_dut (
    .gmii_clk_125m (gmii_clk_125m),
    .arst_n        (arst_n),
    .rgmii_rx_clk  (rgmii_rx_clk),
    .rgmii_rx_dat  (rgmii_rx_dat),
    .rgmii_rx_ctl  (rgmii_rx_ctl),
    .rgmii_gtx_clk (rgmii_gtx_clk),
    .rgmii_tx_dat  (rgmii_tx_dat),
    .rgmii_tx_ctl  (rgmii_tx_ctl),
    .tx_dat        (tx_dat),
    .tx_val        (tx_val),
    .tx_last       (tx_last),
    .tx_abort      (tx_abort),
    .tx_ack        (tx_ack),
    .gmii_rx_clk   (gmii_rx_clk),
    .rx_dat        (rx_dat),
    .rx_val        (rx_val),
    .rx_end        (rx_end),
    .rx_ok         (rx_ok),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata)
  );

  always #2 gmii_clk_125m = ~gmii_clk_125m;

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(next_random() % 32'(hi - lo + 1));
  endfunction

  task automatic report_problem(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic check_byte(input string name, input eth_pkg::byte_t got,
                            input eth_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input eth_pkg::reg_data_t got,
                             input eth_pkg::reg_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  // Register tasks start and end on a falling edge.
  task automatic write_reg(input eth_pkg::reg_addr_t addr, input eth_pkg::reg_data_t data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge gmii_clk_125m);
    reg_wr    = 1'b0;
  endtask

  task automatic read_reg(input eth_pkg::reg_addr_t addr, output eth_pkg::reg_data_t data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge gmii_clk_125m);
    reg_rd   = 1'b0;
    data     = reg_rdata;
  endtask

  // Abort position below zero sends a complete frame.
  task automatic send_frame(input int len, input int abort_at, input logic rx_on);
    eth_pkg::byte_t payload [40];
    int             i;
    int             kept;
    int             wait_cycles;
    logic           taken;
    logic           done;
    for (i = 0; i < len; i++) begin
      payload[i] = eth_pkg::byte_t'(next_random());
    end
    // Receive side holds back the last 4 bytes after SFD.
    kept = (abort_at < 0) ? len : abort_at + 1 - 4;
    if (kept < 0) begin
      kept = 0;
    end
    if (abort_at < 0) begin
      tx_cnt_m++;
    end
    if (rx_on) begin
      for (i = 0; i < kept; i++) begin
        exp_bytes.push_back(payload[i]);
      end
      exp_len.push_back(kept);
      exp_ok.push_back(abort_at < 0);
      if (abort_at < 0) begin
        rx_ok_m++;
      end else begin
        rx_bad_m++;
      end
    end
    i           = 0;
    wait_cycles = 0;
    done        = 1'b0;
    tx_val      = 1'b1;
    tx_dat      = payload[0];
    tx_last     = (len == 1);
    tx_abort    = (abort_at == 0);
    while (!done) begin
      taken = tx_ack;
      if (taken) begin
        if ((i == len - 1) || (i == abort_at)) begin
          done = 1'b1;
        end
      end else begin
        wait_cycles++;
        if (wait_cycles > 100) begin
          report_problem("tx_ack never came for a waiting payload byte");
          done = 1'b1;
        end
      end
      @(negedge gmii_clk_125m);
      if (taken && !done) begin
        i++;
        tx_dat   = payload[i];
        tx_last  = (i == len - 1);
        tx_abort = (i == abort_at);
      end
    end
    tx_val   = 1'b0;
    tx_last  = 1'b0;
    tx_abort = 1'b0;
  endtask

  // Samples mid high phase, where ctl shows the frame's val.
  task automatic sample_ctl_until(input logic level, output int samples);
    samples = 0;
    do begin
      @(posedge gmii_clk_125m);
      #1;
      samples++;
    end while ((rgmii_tx_ctl !== level) && (samples < 500));
    if (rgmii_tx_ctl !== level) begin
      report_problem("rgmii_tx_ctl did not change, gap not measured");
    end
  endtask

  task automatic measure_gap(output int gap);
    int skipped;
    sample_ctl_until(1'b1, skipped);
    sample_ctl_until(1'b0, skipped);
    sample_ctl_until(1'b1, gap);
  endtask

  task automatic wait_rx_done();
    int cycles;
    cycles = 0;
    while ((exp_ok.size() != 0) && (cycles < 300)) begin
      @(negedge gmii_clk_125m);
      cycles++;
    end
    if (exp_ok.size() != 0) begin
      report_problem("receive side did not end all expected frames");
    end
    if (exp_bytes.size() != 0) begin
      report_problem("receive side did not deliver all expected bytes");
    end
    exp_bytes.delete();
    exp_len.delete();
    exp_ok.delete();
    // Counter updates lag the receive events.
    repeat (6) @(negedge gmii_clk_125m);
  endtask

  task automatic wait_tx_count(input int expected);
    eth_pkg::reg_data_t rd;
    int                 polls;
    polls = 0;
    read_reg(`REG_TX_CNT, rd);
    while ((rd != eth_pkg::reg_data_t'(expected)) && (polls < 200)) begin
      read_reg(`REG_TX_CNT, rd);
      polls++;
    end
    check_count("reg_rdata tx count", rd, eth_pkg::reg_data_t'(expected));
  endtask

  always @(negedge gmii_rx_clk) begin
    if (arst_n) begin
      if (rx_val) begin
        if (exp_bytes.size() == 0) begin
          report_problem("rx_val came with no byte expected");
        end else begin
          check_byte("rx_dat", rx_dat, exp_bytes.pop_front());
        end
        rx_bytes++;
      end
      if (rx_end) begin
        if (exp_ok.size() == 0) begin
          report_problem("rx_end came with no frame expected");
        end else begin
          check_flag("rx_ok", rx_ok, exp_ok.pop_front());
          check_count("rx_val count", eth_pkg::reg_data_t'(rx_bytes),
                      eth_pkg::reg_data_t'(exp_len.pop_front()));
        end
        rx_bytes = 0;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 4);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int                 e0;
    int                 len;
    int                 ipg;
    int                 gap;
    eth_pkg::reg_data_t rd;
    gmii_clk_125m = 1'b0;
    arst_n        = 1'b0;
    tx_dat        = '0;
    tx_val        = 1'b0;
    tx_last       = 1'b0;
    tx_abort      = 1'b0;
    reg_wr        = 1'b0;
    reg_rd        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    rng           = 32'd29;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    tx_cnt_m      = 0;
    rx_ok_m       = 0;
    rx_bad_m      = 0;
    rx_bytes      = 0;
    repeat (8) @(negedge gmii_clk_125m);
    arst_n = 1'b1;
    @(negedge gmii_clk_125m);

    e0 = errors;
    read_reg(`REG_CTRL, rd);
    check_count("reg_rdata ctrl", rd, `ETH_CTRL_DEFAULT);
    read_reg(`REG_IPG, rd);
    check_count("reg_rdata ipg", rd, `ETH_IPG_DEFAULT);
    write_reg(`REG_IPG, 16'h0000);
    read_reg(`REG_IPG, rd);
    check_count("reg_rdata ipg", rd, `ETH_IPG_MIN);
    write_reg(`REG_IPG, `ETH_IPG_DEFAULT);
    finish_test("reset values", e0);

    e0 = errors;
    repeat (8) send_frame(rand_range(1, 40), -1, 1'b1);
    wait_rx_done();
    finish_test("random frames", e0);

    e0 = errors;
    repeat (3) begin
      len = rand_range(1, 40);
      send_frame(len, rand_range(0, len - 1), 1'b1);
    end
    wait_rx_done();
    finish_test("aborted frames", e0);

    e0 = errors;
    read_reg(`REG_TX_CNT, rd);
    check_count("reg_rdata tx count", rd, eth_pkg::reg_data_t'(tx_cnt_m));
    read_reg(`REG_RX_OK_CNT, rd);
    check_count("reg_rdata rx ok count", rd, eth_pkg::reg_data_t'(rx_ok_m));
    read_reg(`REG_RX_BAD_CNT, rd);
    check_count("reg_rdata rx bad count", rd, eth_pkg::reg_data_t'(rx_bad_m));
    for (int a = `REG_TX_CNT; a <= `REG_RX_BAD_CNT; a++) begin
      write_reg(eth_pkg::reg_addr_t'(a), 16'h0000);
      read_reg(eth_pkg::reg_addr_t'(a), rd);
      check_count("reg_rdata cleared counter", rd, 16'h0000);
    end
    tx_cnt_m = 0;
    rx_ok_m  = 0;
    rx_bad_m = 0;
    finish_test("counters", e0);

    e0 = errors;
    ipg = rand_range(1, 30);
    write_reg(`REG_IPG, eth_pkg::reg_data_t'(ipg));
    fork
      begin
        send_frame(rand_range(1, 40), -1, 1'b1);
        send_frame(rand_range(1, 40), -1, 1'b1);
      end
      measure_gap(gap);
    join
    check_count("rgmii_tx_ctl low cycles", eth_pkg::reg_data_t'(gap),
                eth_pkg::reg_data_t'(ipg));
    wait_rx_done();
    finish_test("inter-packet gap", e0);

    e0 = errors;
    write_reg(`REG_CTRL, 16'h0001);
    repeat (2) send_frame(rand_range(1, 40), -1, 1'b0);
    wait_tx_count(tx_cnt_m);
    // Loopback and parser latency window.
    repeat (20) @(negedge gmii_clk_125m);
    read_reg(`REG_RX_OK_CNT, rd);
    check_count("reg_rdata rx ok count", rd, eth_pkg::reg_data_t'(rx_ok_m));
    read_reg(`REG_RX_BAD_CNT, rd);
    check_count("reg_rdata rx bad count", rd, eth_pkg::reg_data_t'(rx_bad_m));
    write_reg(`REG_CTRL, `ETH_CTRL_DEFAULT);
    finish_test("receive disabled", e0);

    errors = errors + i_dut.i_chk.failures;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : eth_rgmii_tb
